// ==== common/qracc_pkg.sv ====
/* Shared definitions for the QRAcc sequencing controller: layer configuration,
   mode and trigger enums, data bus and compute stage structs, output size helper */
`default_nettype none

package qracc_pkg;

    //////////////////////////////////////////////////
    // Layer configuration
    //////////////////////////////////////////////////

    typedef struct packed {
        logic [15:0] input_fmap_dimx;
        logic [15:0] input_fmap_dimy;
        logic [15:0] num_input_channels;
        logic [15:0] num_output_channels;
        logic [3:0]  filter_size_x;
        logic [3:0]  filter_size_y;
        logic [3:0]  stride_x;
        logic [3:0]  stride_y;
        // Bits per activation element, one of 1, 2, 4 or 8
        logic [3:0]  n_input_bits_cfg;
    } qracc_cfg_t;

    //////////////////////////////////////////////////
    // Modes
    //////////////////////////////////////////////////

    typedef enum logic [1:0] {
        TRIGGER_IDLE            = 2'd0,
        TRIGGER_LOAD_ACTIVATION = 2'd1,
        TRIGGER_COMPUTE         = 2'd2,
        TRIGGER_READ_ACTIVATION = 2'd3
    } qracc_trigger_e;

    typedef enum logic [1:0] {
        S_IDLE     = 2'd0,
        S_LOADACTS = 2'd1,
        S_COMPUTE  = 2'd2,
        S_READACTS = 2'd3
    } qracc_state_e;

    //////////////////////////////////////////////////
    // Bus and stage payloads
    //////////////////////////////////////////////////

    typedef struct packed {
        logic        valid;
        logic        wen;
        logic [31:0] data;
    } qracc_bus_req_t;

    typedef struct packed {
        logic        ready;
        logic        rd_data_valid;
        logic [31:0] rd_addr;
    } qracc_bus_rsp_t;

    // Walker to feature stage
    typedef struct packed {
        logic [31:0] rd_addr;
        logic [31:0] feat_addr;
        logic        last;
    } qracc_window_t;

    typedef struct packed {
        logic        en;
        logic [31:0] addr;
    } qracc_act_wr_t;

    // Output map extent along one axis, no padding
    function automatic logic [31:0] out_dim(logic [15:0] in_dim, logic [3:0] filt,
                                            logic [3:0] stride);
        return (32'(in_dim) - 32'(filt)) / 32'(stride) + 32'd1;
    endfunction

endpackage

`default_nettype wire

// ==== source/qracc_mode_fsm.sv ====
/* Mode FSM with activation load and read-out pointers
   and the ping-pong ifmap/ofmap start addresses */
`default_nettype none

module qracc_mode_fsm #(
    parameter int BUS_W = 32
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  qracc_pkg::qracc_cfg_t     cfg_i,
    input  qracc_pkg::qracc_trigger_e trigger_i,
    input  qracc_pkg::qracc_bus_req_t bus_req_i,
    input  logic                      compute_done_i,
    input  logic [31:0]               ofmap_len_i,
    output qracc_pkg::qracc_bus_rsp_t bus_rsp_o,
    output qracc_pkg::qracc_state_e   state_o,
    output logic                      busy_o,
    output qracc_pkg::qracc_act_wr_t  load_wr_o,
    output logic [31:0]               ofmap_start_o
);
    import qracc_pkg::*;

    qracc_state_e state_q;
    qracc_state_e state_d;
    logic         ready_q;
    logic         rd_valid_q;
    logic [31:0]  ifmap_start_q;
    logic [31:0]  ofmap_start_q;
    logic [31:0]  wr_ptr_q;
    logic [31:0]  rd_ptr_q;
    logic [31:0]  step;
    logic [31:0]  ifmap_size;
    logic         load_xfer;
    logic         read_xfer;
    logic         load_last;
    logic         read_last;

    // Elements packed in one bus word
    assign step       = 32'(BUS_W) / 32'(cfg_i.n_input_bits_cfg);
    assign ifmap_size = 32'(cfg_i.input_fmap_dimx) * 32'(cfg_i.input_fmap_dimy)
                      * 32'(cfg_i.num_input_channels);

    assign load_xfer = bus_req_i.valid && ready_q && bus_req_i.wen && (state_q == S_LOADACTS);
    assign read_xfer = bus_req_i.valid && ready_q && !bus_req_i.wen && (state_q == S_READACTS);
    assign load_last = load_xfer && (wr_ptr_q + step >= ifmap_size);
    assign read_last = read_xfer && (rd_ptr_q + 32'd4 >= ofmap_len_i);

    //////////////////////////////////////////////////
    // Next state
    //////////////////////////////////////////////////

    always_comb begin
        state_d = state_q;
        case (state_q)
            S_IDLE: begin
                case (trigger_i)
                    TRIGGER_LOAD_ACTIVATION: state_d = S_LOADACTS;
                    TRIGGER_COMPUTE:         state_d = S_COMPUTE;
                    TRIGGER_READ_ACTIVATION: state_d = S_READACTS;
                    default:                 state_d = S_IDLE;
                endcase
            end
            S_LOADACTS: begin
                if (load_last) begin
                    state_d = S_IDLE;
                end
            end
            S_COMPUTE: begin
                if (compute_done_i) begin
                    state_d = S_IDLE;
                end
            end
            S_READACTS: begin
                if (read_last) begin
                    state_d = S_IDLE;
                end
            end
        endcase
    end

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            state_q    <= S_IDLE;
            ready_q    <= 1'b0;
            rd_valid_q <= 1'b0;
        end else begin
            state_q    <= state_d;
            // Bus is blocked only while computing
            ready_q    <= (state_d != S_COMPUTE);
            rd_valid_q <= read_xfer;
        end
    end

    //////////////////////////////////////////////////
    // Pointers and ping-pong starts
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            ifmap_start_q <= '0;
            ofmap_start_q <= '0;
            wr_ptr_q      <= '0;
            rd_ptr_q      <= '0;
        end else begin
            case (state_q)
                S_IDLE: begin
                    // A fresh load always lands at the bottom of the buffer
                    if (state_d == S_LOADACTS) begin
                        ifmap_start_q <= '0;
                    end
                end
                S_LOADACTS: begin
                    if (load_last) begin
                        wr_ptr_q      <= '0;
                        ofmap_start_q <= ifmap_start_q + wr_ptr_q + step;
                    end else if (load_xfer) begin
                        wr_ptr_q <= wr_ptr_q + step;
                    end
                end
                S_COMPUTE: begin
                    // Swap so the next layer reads this output
                    if (compute_done_i) begin
                        ifmap_start_q <= ofmap_start_q;
                        ofmap_start_q <= ofmap_start_q + ofmap_len_i;
                    end
                end
                S_READACTS: begin
                    if (read_last) begin
                        rd_ptr_q <= '0;
                    end else if (read_xfer) begin
                        rd_ptr_q <= rd_ptr_q + 32'd4;
                    end
                end
            endcase
        end
    end

    assign bus_rsp_o.ready         = ready_q;
    assign bus_rsp_o.rd_data_valid = rd_valid_q;
    assign bus_rsp_o.rd_addr       = (state_q == S_READACTS) ? ifmap_start_q + rd_ptr_q : '0;

    assign load_wr_o.en   = load_xfer;
    assign load_wr_o.addr = load_xfer ? ifmap_start_q + wr_ptr_q : '0;

    assign state_o       = state_q;
    assign busy_o        = (state_q != S_IDLE);
    assign ofmap_start_o = ofmap_start_q;

endmodule

`default_nettype wire

// ==== window/qracc_window_walker.sv ====
/* Compute stage 1: convolution window walker producing
   activation buffer read and feature-loader addresses */
`default_nettype none

module qracc_window_walker #(
    parameter int IFACE_ELEMS = 16
) (
    input  logic                     clk,
    input  logic                     nrst,
    input  qracc_pkg::qracc_cfg_t    cfg_i,
    input  logic                     start_i,
    input  logic                     stall_i,
    output qracc_pkg::qracc_window_t win_o,
    output logic                     rd_en_o,
    output logic                     walk_done_o
);
    import qracc_pkg::*;

    logic [31:0] read_set_q;
    logic [3:0]  fy_q;
    logic [31:0] ox_q;
    logic [31:0] oy_q;
    logic        done_q;
    logic [31:0] chans;
    logic [31:0] num_sets;
    logic [31:0] ox_dim;
    logic [31:0] oy_dim;
    logic [31:0] row;
    logic        last_set;
    logic        last_row;
    logic        last_ox;
    logic        last_oy;

    assign chans = 32'(cfg_i.num_input_channels);
    // Read sets needed to cover one filter row of C*Fx elements
    assign num_sets = (chans * 32'(cfg_i.filter_size_x) + 32'(IFACE_ELEMS) - 32'd1)
                    / 32'(IFACE_ELEMS);
    assign ox_dim = out_dim(cfg_i.input_fmap_dimx, cfg_i.filter_size_x, cfg_i.stride_x);
    assign oy_dim = out_dim(cfg_i.input_fmap_dimy, cfg_i.filter_size_y, cfg_i.stride_y);

    assign last_set = (read_set_q == num_sets - 32'd1);
    assign last_row = (fy_q == cfg_i.filter_size_y - 4'd1);
    assign last_ox  = (ox_q == ox_dim - 32'd1);
    assign last_oy  = (oy_q == oy_dim - 32'd1);

    assign rd_en_o     = start_i && !stall_i && !done_q;
    assign walk_done_o = done_q;

    // Buffer layout is h*W*C + w*C + c
    assign row = oy_q * 32'(cfg_i.stride_y) + 32'(fy_q);
    assign win_o.rd_addr = chans * 32'(cfg_i.input_fmap_dimx) * row
                         + chans * (ox_q * 32'(cfg_i.stride_x))
                         + read_set_q * 32'(IFACE_ELEMS);
    assign win_o.feat_addr = 32'(fy_q) * chans * 32'(cfg_i.filter_size_x)
                           + read_set_q * 32'(IFACE_ELEMS);
    assign win_o.last = last_set && last_row;

    //////////////////////////////////////////////////
    // Counters, read set innermost
    //////////////////////////////////////////////////

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            read_set_q <= '0;
            fy_q       <= '0;
            ox_q       <= '0;
            oy_q       <= '0;
            done_q     <= 1'b0;
        end else if (!start_i) begin
            read_set_q <= '0;
            fy_q       <= '0;
            ox_q       <= '0;
            oy_q       <= '0;
            done_q     <= 1'b0;
        end else if (rd_en_o) begin
            if (!last_set) begin
                read_set_q <= read_set_q + 32'd1;
            end else begin
                read_set_q <= '0;
                if (!last_row) begin
                    fy_q <= fy_q + 4'd1;
                end else begin
                    fy_q <= '0;
                    if (!last_ox) begin
                        ox_q <= ox_q + 32'd1;
                    end else begin
                        ox_q <= '0;
                        if (!last_oy) begin
                            oy_q <= oy_q + 32'd1;
                        end else begin
                            oy_q   <= '0;
                            done_q <= 1'b1;
                        end
                    end
                end
            end
        end
    end

endmodule

`default_nettype wire

// ==== window/qracc_feature_stage.sv ====
/* Compute stage 2: feature-loader slot that holds
   under MAC back-pressure and forms the stall */
`default_nettype none

module qracc_feature_stage (
    input  logic                     clk,
    input  logic                     nrst,
    input  qracc_pkg::qracc_window_t win_i,
    input  logic                     rd_en_i,
    input  logic                     mac_ready_i,
    output logic                     feat_valid_o,
    output logic [31:0]              feat_addr_o,
    output logic                     mac_valid_o,
    output logic                     stall_o,
    output logic                     empty_o
);

    logic        valid_q;
    logic        last_q;
    logic [31:0] addr_q;

    // MAC array not taking the word it is shown
    assign stall_o = valid_q && !mac_ready_i;

    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            valid_q <= 1'b0;
            last_q  <= 1'b0;
        end else if (!stall_o) begin
            valid_q <= rd_en_i;
            last_q  <= rd_en_i && win_i.last;
        end
    end

    always_ff @(posedge clk) begin
        if (!stall_o) begin
            addr_q <= win_i.feat_addr;
        end
    end

    assign feat_valid_o = valid_q;
    assign feat_addr_o  = addr_q;
    // Last read set of the last filter row closes a window
    assign mac_valid_o  = valid_q && last_q;
    assign empty_o      = !valid_q;

endmodule

`default_nettype wire

// ==== source/qracc_writeback.sv ====
/* Compute stage 3: output pixel counter and ofmap write addresses */
`default_nettype none

module qracc_writeback (
    input  logic                     clk,
    input  logic                     nrst,
    input  qracc_pkg::qracc_cfg_t    cfg_i,
    input  logic                     active_i,
    input  logic                     mac_out_valid_i,
    input  logic [31:0]              ofmap_start_i,
    output qracc_pkg::qracc_act_wr_t wb_o,
    output logic [31:0]              ofmap_len_o,
    output logic                     all_written_o
);
    import qracc_pkg::*;

    logic [31:0] out_chans;
    logic [31:0] n_pixels;
    logic [31:0] pix_q;
    logic [31:0] offset_q;
    logic        wr_en;

    assign out_chans = 32'(cfg_i.num_output_channels);
    assign n_pixels  = out_dim(cfg_i.input_fmap_dimx, cfg_i.filter_size_x, cfg_i.stride_x)
                     * out_dim(cfg_i.input_fmap_dimy, cfg_i.filter_size_y, cfg_i.stride_y);

    // Full ofmap length, also the read-out length after the swap
    assign ofmap_len_o = n_pixels * out_chans;

    assign wr_en       = active_i && mac_out_valid_i;
    assign wb_o.en     = wr_en;
    assign wb_o.addr   = wr_en ? ofmap_start_i + offset_q : '0;
    assign all_written_o = (pix_q == n_pixels);

    // Each pixel occupies one slot of Cout elements
    always_ff @(posedge clk or negedge nrst) begin
        if (!nrst) begin
            pix_q    <= '0;
            offset_q <= '0;
        end else if (!active_i) begin
            pix_q    <= '0;
            offset_q <= '0;
        end else if (wr_en) begin
            pix_q    <= pix_q + 32'd1;
            offset_q <= offset_q + out_chans;
        end
    end

endmodule

`default_nettype wire

// ==== source/qracc_controller.sv ====
/* QRAcc sequencing controller top: mode FSM plus the
   walker, feature and writeback compute pipeline */
`default_nettype none

module qracc_controller #(
    parameter int ADDR_W      = 32,
    parameter int BUS_W       = 32,
    parameter int IFACE_ELEMS = 16
) (
    input  logic                      clk,
    input  logic                      nrst,
    input  qracc_pkg::qracc_cfg_t     cfg_i,
    input  qracc_pkg::qracc_trigger_e trigger_i,
    input  qracc_pkg::qracc_bus_req_t bus_req_i,
    input  logic                      mac_ready_i,
    input  logic                      mac_out_valid_i,
    output qracc_pkg::qracc_bus_rsp_t bus_rsp_o,
    output qracc_pkg::qracc_state_e   state_o,
    output logic                      busy_o,
    output logic                      act_rd_en_o,
    output logic [ADDR_W-1:0]         act_rd_addr_o,
    output logic                      feat_valid_o,
    output logic [ADDR_W-1:0]         feat_addr_o,
    output logic                      mac_valid_o,
    output qracc_pkg::qracc_act_wr_t  act_wr_o
);
    import qracc_pkg::*;

    qracc_window_t win;
    qracc_act_wr_t load_wr;
    qracc_act_wr_t wb_wr;
    logic          computing;
    logic          walk_done;
    logic          stall;
    logic          feat_empty;
    logic          all_written;
    logic          compute_done;
    logic [31:0]   ofmap_len;
    logic [31:0]   ofmap_start;
    logic [31:0]   feat_addr;

    assign computing    = (state_o == S_COMPUTE);
    // Walker finished, slot drained and every pixel written back
    assign compute_done = walk_done && feat_empty && all_written;

    qracc_mode_fsm #(
        .BUS_W(BUS_W)
    ) i_mode_fsm (
        .clk           (clk),
        .nrst          (nrst),
        .cfg_i         (cfg_i),
        .trigger_i     (trigger_i),
        .bus_req_i     (bus_req_i),
        .compute_done_i(compute_done),
        .ofmap_len_i   (ofmap_len),
        .bus_rsp_o     (bus_rsp_o),
        .state_o       (state_o),
        .busy_o        (busy_o),
        .load_wr_o     (load_wr),
        .ofmap_start_o (ofmap_start)
    );

    qracc_window_walker #(
        .IFACE_ELEMS(IFACE_ELEMS)
    ) i_window_walker (
        .clk        (clk),
        .nrst       (nrst),
        .cfg_i      (cfg_i),
        .start_i    (computing),
        .stall_i    (stall),
        .win_o      (win),
        .rd_en_o    (act_rd_en_o),
        .walk_done_o(walk_done)
    );

    qracc_feature_stage i_feature_stage (
        .clk         (clk),
        .nrst        (nrst),
        .win_i       (win),
        .rd_en_i     (act_rd_en_o),
        .mac_ready_i (mac_ready_i),
        .feat_valid_o(feat_valid_o),
        .feat_addr_o (feat_addr),
        .mac_valid_o (mac_valid_o),
        .stall_o     (stall),
        .empty_o     (feat_empty)
    );

    qracc_writeback i_writeback (
        .clk            (clk),
        .nrst           (nrst),
        .cfg_i          (cfg_i),
        .active_i       (computing),
        .mac_out_valid_i(mac_out_valid_i),
        .ofmap_start_i  (ofmap_start),
        .wb_o           (wb_wr),
        .ofmap_len_o    (ofmap_len),
        .all_written_o  (all_written)
    );

    assign act_rd_addr_o = ADDR_W'(win.rd_addr);
    assign feat_addr_o   = ADDR_W'(feat_addr);

    // Load and writeback never overlap, idle sources drive zero
    assign act_wr_o = load_wr | wb_wr;

endmodule

`default_nettype wire

// ==== tests/qracc_properties.sv ====
/* Bound checks on the feature stage for stall hold, no read
   while stalled and feature valid one cycle after a read */
`default_nettype none

module qracc_properties (
    input logic        clk,
    input logic        nrst,
    input logic        rd_en_i,
    input logic        mac_ready_i,
    input logic        feat_valid_i,
    input logic [31:0] feat_addr_i,
    input logic        mac_valid_i
);

    // Assertion failures so far
    int fail_count = 0;

    // Held word keeps its address and marker until the MAC array takes it
    hold_stable: assert property (@(posedge clk) disable iff (!nrst)
        feat_valid_i && !mac_ready_i |=> feat_valid_i && $stable(feat_addr_i)
            && $stable(mac_valid_i))
        else begin
            fail_count = fail_count + 1;
            $error("feature word changed while stalled");
        end

    no_read_in_stall: assert property (@(posedge clk) disable iff (!nrst)
        feat_valid_i && !mac_ready_i |-> !rd_en_i)
        else begin
            fail_count = fail_count + 1;
            $error("activation read issued while stalled");
        end

    valid_after_read: assert property (@(posedge clk) disable iff (!nrst)
        rd_en_i |=> feat_valid_i)
        else begin
            fail_count = fail_count + 1;
            $error("feature valid missing one cycle after a read");
        end

endmodule

bind qracc_feature_stage qracc_properties i_feature_props (
    .clk         (clk),
    .nrst        (nrst),
    .rd_en_i     (rd_en_i),
    .mac_ready_i (mac_ready_i),
    .feat_valid_i(feat_valid_o),
    .feat_addr_i (feat_addr_o),
    .mac_valid_i (mac_valid_o)
);

`default_nettype wire

// ==== tests/qracc_tb.sv ====
/* Testbench for the QRAcc controller with load, compute under random MAC
   back-pressure and read-out after the swap, checked against reference address models */
`default_nettype none

module qracc_tb;
    import qracc_pkg::*;

    localparam int ADDR_W      = 32;
    localparam int BUS_W       = 32;
    localparam int IFACE_ELEMS = 16;
    localparam int TIMEOUT     = 2000;

    // Layer under test
    localparam int WI    = 6;
    localparam int HI    = 5;
    localparam int CIN   = 8;
    localparam int COUT  = 3;
    localparam int FX    = 3;
    localparam int FY    = 3;
    localparam int SX    = 1;
    localparam int SY    = 2;
    localparam int NBITS = 4;

    localparam int OX         = (WI - FX) / SX + 1;
    localparam int OY         = (HI - FY) / SY + 1;
    localparam int NPIX       = OX * OY;
    localparam int NSETS      = (CIN * FX + IFACE_ELEMS - 1) / IFACE_ELEMS;
    localparam int NREADS     = NPIX * FY * NSETS;
    localparam int STEP       = BUS_W / NBITS;
    localparam int LOAD_WORDS = (WI * HI * CIN + STEP - 1) / STEP;
    localparam int OFMAP_BASE = LOAD_WORDS * STEP;
    localparam int NRO        = (NPIX * COUT + 3) / 4;

    logic           clk = 1'b0;
    logic           nrst;
    qracc_cfg_t     cfg_i;
    qracc_trigger_e trigger_i;
    qracc_bus_req_t bus_req_i;
    logic           mac_ready_i = 1'b0;
    logic           mac_out_valid_i = 1'b0;
    qracc_bus_rsp_t bus_rsp_o;
    qracc_state_e   state_o;
    logic           busy_o;
    logic           act_rd_en_o;
    logic [31:0]    act_rd_addr_o;
    logic           feat_valid_o;
    logic [31:0]    feat_addr_o;
    logic           mac_valid_o;
    qracc_act_wr_t  act_wr_o;

    integer      seed = 32'h6b292c32;
    logic [31:0] rnd;
    int          pending = 0;
    int          n_ld = 0;
    int          n_rd = 0;
    int          n_feat = 0;
    int          n_wb = 0;
    int          n_ro = 0;
    logic        ro_prev = 1'b0;

    qracc_controller #(
        .ADDR_W     (ADDR_W),
        .BUS_W      (BUS_W),
        .IFACE_ELEMS(IFACE_ELEMS)
    ) i_qracc_controller (
        .clk            (clk),
        .nrst           (nrst),
        .cfg_i          (cfg_i),
        .trigger_i      (trigger_i),
        .bus_req_i      (bus_req_i),
        .mac_ready_i    (mac_ready_i),
        .mac_out_valid_i(mac_out_valid_i),
        .bus_rsp_o      (bus_rsp_o),
        .state_o        (state_o),
        .busy_o         (busy_o),
        .act_rd_en_o    (act_rd_en_o),
        .act_rd_addr_o  (act_rd_addr_o),
        .feat_valid_o   (feat_valid_o),
        .feat_addr_o    (feat_addr_o),
        .mac_valid_o    (mac_valid_o),
        .act_wr_o       (act_wr_o)
    );

    always #10 clk = ~clk;

    //////////////////////////////////////////////////
    // Reference model and checking
    //////////////////////////////////////////////////

    // Read set innermost, then filter row, then ox, then oy
    function automatic void window_ref(input int idx, output logic [31:0] rd,
                                       output logic [31:0] feat, output logic last);
        int rs;
        int fy;
        int ox;
        int oy;
        rs   = idx % NSETS;
        fy   = (idx / NSETS) % FY;
        ox   = (idx / (NSETS * FY)) % OX;
        oy   = idx / (NSETS * FY * OX);
        rd   = 32'(CIN * WI * (oy * SY + fy) + CIN * ox * SX + rs * IFACE_ELEMS);
        feat = 32'(fy * CIN * FX + rs * IFACE_ELEMS);
        last = (rs == NSETS - 1) && (fy == FY - 1);
    endfunction

    task automatic fail_run(input string why);
        $display("%s", why);
        $display("TEST FAIL");
        $fatal(1, "simulation stopped on first error");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] expected);
        if (got !== expected) begin
            $display("mismatch at %0t: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
            fail_run("stopping at first mismatch");
        end
    endtask

    // Compare every DUT event mid-cycle
    always @(negedge clk) begin : compare
        logic [31:0] rd_ref;
        logic [31:0] feat_ref;
        logic        last_ref;
        if (nrst) begin
            check("rd_data_valid", 32'(bus_rsp_o.rd_data_valid), 32'(ro_prev));
            ro_prev = bus_req_i.valid && !bus_req_i.wen && bus_rsp_o.ready
                      && (state_o == S_READACTS);
            if (ro_prev) begin
                check("rd_addr", bus_rsp_o.rd_addr, 32'(OFMAP_BASE + 4 * n_ro));
                n_ro++;
            end
            if (act_rd_en_o) begin
                if (n_rd >= NREADS) begin
                    fail_run("walker issued a read past the last window");
                end
                window_ref(n_rd, rd_ref, feat_ref, last_ref);
                check("act_rd_addr_o", act_rd_addr_o, rd_ref);
                n_rd++;
            end
            // Word taken by the MAC array
            if (feat_valid_o && mac_ready_i) begin
                window_ref(n_feat, rd_ref, feat_ref, last_ref);
                check("feat_addr_o", feat_addr_o, feat_ref);
                check("mac_valid_o", 32'(mac_valid_o), 32'(last_ref));
                n_feat++;
            end
            if (act_wr_o.en) begin
                if (state_o == S_LOADACTS) begin
                    check("act_wr_o.addr", act_wr_o.addr, 32'(n_ld * STEP));
                    n_ld++;
                end else if (state_o == S_COMPUTE) begin
                    check("act_wr_o.addr", act_wr_o.addr, 32'(OFMAP_BASE + n_wb * COUT));
                    n_wb++;
                end else begin
                    fail_run("activation write strobe outside load and compute");
                end
            end
        end
    end

    // MAC array model with one result pulse per accepted window
    always @(posedge clk) begin
        rnd = $random(seed);
        if (mac_valid_o && mac_ready_i) begin
            pending = pending + 1;
        end
        if (pending > 0 && rnd[2]) begin
            mac_out_valid_i <= 1'b1;
            pending = pending - 1;
        end else begin
            mac_out_valid_i <= 1'b0;
        end
        mac_ready_i <= (rnd[1:0] != 2'b00);
    end

    //////////////////////////////////////////////////
    // Stimulus
    //////////////////////////////////////////////////

    task automatic pulse_trigger(input qracc_trigger_e t);
        @(posedge clk);
        trigger_i <= t;
        @(posedge clk);
        trigger_i <= TRIGGER_IDLE;
    endtask

    task automatic bus_xfer(input logic wen, input logic [31:0] data);
        int n;
        n = 0;
        @(posedge clk);
        bus_req_i <= '{valid: 1'b1, wen: wen, data: data};
        @(negedge clk);
        while (!bus_rsp_o.ready && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (!bus_rsp_o.ready) begin
            fail_run("timeout waiting for bus ready");
        end
        @(posedge clk);
        bus_req_i <= '0;
    endtask

    task automatic wait_for_state(input qracc_state_e want, input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (state_o != want && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (state_o != want) begin
            fail_run({"timeout waiting for ", what});
        end
    endtask

    task automatic wait_while_busy(input string what);
        int n;
        n = 0;
        @(negedge clk);
        while (busy_o && n < TIMEOUT) begin
            n++;
            @(negedge clk);
        end
        if (busy_o) begin
            fail_run({"timeout waiting for ", what});
        end
    endtask

    initial begin
        nrst      = 1'b0;
        trigger_i = TRIGGER_IDLE;
        bus_req_i = '0;
        cfg_i     = '{input_fmap_dimx: 16'(WI), input_fmap_dimy: 16'(HI),
                      num_input_channels: 16'(CIN), num_output_channels: 16'(COUT),
                      filter_size_x: 4'(FX), filter_size_y: 4'(FY),
                      stride_x: 4'(SX), stride_y: 4'(SY), n_input_bits_cfg: 4'(NBITS)};
        repeat (3) @(negedge clk);
        check("busy_o", 32'(busy_o), 32'd0);
        check("ready", 32'(bus_rsp_o.ready), 32'd0);
        check("act_rd_en_o", 32'(act_rd_en_o), 32'd0);
        check("feat_valid_o", 32'(feat_valid_o), 32'd0);
        check("act_wr_o.en", 32'(act_wr_o.en), 32'd0);
        check("state_o", 32'(state_o), 32'(S_IDLE));
        @(posedge clk);
        nrst <= 1'b1;
        @(posedge clk);

        // Activation load from address zero
        pulse_trigger(TRIGGER_LOAD_ACTIVATION);
        for (int i = 0; i < LOAD_WORDS; i++) begin
            bus_xfer(1'b1, 32'(i));
        end
        @(negedge clk);
        check("state_o", 32'(state_o), 32'(S_IDLE));
        check("load words", 32'(n_ld), 32'(LOAD_WORDS));

        // Compute until busy falls after the last writeback
        pulse_trigger(TRIGGER_COMPUTE);
        wait_for_state(S_COMPUTE, "compute start");
        wait_while_busy("compute end");
        check("act reads", 32'(n_rd), 32'(NREADS));
        check("feature words", 32'(n_feat), 32'(NREADS));
        check("writebacks", 32'(n_wb), 32'(NPIX));

        // Read-out starts at the old ofmap start
        pulse_trigger(TRIGGER_READ_ACTIVATION);
        for (int i = 0; i < NRO; i++) begin
            bus_xfer(1'b0, 32'd0);
        end
        @(negedge clk);
        check("state_o", 32'(state_o), 32'(S_IDLE));
        check("read-out words", 32'(n_ro), 32'(NRO));
        @(negedge clk);

        if (i_qracc_controller.i_feature_stage.i_feature_props.fail_count == 0) begin
            $display("TEST PASS");
            $finish;
        end else begin
            fail_run("feature stage assertions failed");
        end
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
common/qracc_pkg.sv
source/qracc_mode_fsm.sv
window/qracc_window_walker.sv
window/qracc_feature_stage.sv
source/qracc_writeback.sv
source/qracc_controller.sv
tests/qracc_properties.sv
tests/qracc_tb.sv

// ==== run.sh ====
#!/bin/sh
# Compile and run the controller testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --top-module qracc_tb -f filelist.f -o qracc_sim
out=$(./obj_dir/qracc_sim +verilator+error+limit+100 || true)
echo "$out"
echo "$out" | grep -qx "TEST PASS"
